//--- hdl/c_out_stage.sv
module c_out_stage (
  input  logic          clk,
  input  logic          i_reset,
  input  rsa_pkg::op_e  i_mode,
  pe_ctrl_if.out        ctrl,
  input  rsa_pkg::row_t i_acc_row,
  bank_if.out           bank
);
  import rsa_pkg::*;

  // accumulator row captured during drain
  row_t acc_q;

  always_ff @(posedge clk) begin
    if (ctrl.drain_valid) begin
      acc_q <= i_acc_row;
    end
  end

  // M row read on port a lines up with the captured row
  always_comb begin
    for (int j = 0; j < DIM; j++) begin
      if (i_mode == OP_MAC) begin
        bank.din_b[j] = acc_q[j] + bank.dout_a[j];
      end else begin
        bank.din_b[j] = acc_q[j];
      end
    end
  end

  // written row carries known data in every lane
  a_write_known : assert property (
    @(posedge clk) disable iff (i_reset) bank.we_b |-> !$isunknown(bank.din_b)
  ) else $error("c_out_stage: write-back row has unknown lanes");

endmodule

//--- hdl/operand_feed.sv
module operand_feed (
  input  logic          clk,
  input  logic          i_reset,
  bank_if.feed          bank,
  pe_ctrl_if.feed       ctrl,
  output rsa_pkg::row_t o_west_col,
  output rsa_pkg::row_t o_south_row
);
  import rsa_pkg::*;

  // registered selectors, zero outside the valid window
  row_t  a_sel_q;
  row_t  b_sel_q;
  // skewed lanes before packing
  word_t a_lane [DIM];
  word_t b_lane [DIM];

  always_ff @(posedge clk) begin
    if (i_reset) begin
      a_sel_q <= '0;
      b_sel_q <= '0;
    end else begin
      a_sel_q <= ctrl.feed_valid ? bank.dout_a : '0;
      b_sel_q <= ctrl.feed_valid ? bank.dout_b : '0;
    end
  end

  for (genvar i = 0; i < DIM; i++) begin : g_lane
    if (i == 0) begin : g_direct
      // lane 0 enters the array without skew
      assign a_lane[0] = a_sel_q[0];
      assign b_lane[0] = b_sel_q[0];
    end else begin : g_skew
      // lane i delayed by i cycles
      word_t a_dly [i];
      word_t b_dly [i];

      always_ff @(posedge clk) begin
        if (i_reset) begin
          for (int k = 0; k < i; k++) begin
            a_dly[k] <= '0;
            b_dly[k] <= '0;
          end
        end else begin
          a_dly[0] <= a_sel_q[i];
          b_dly[0] <= b_sel_q[i];
          for (int k = 1; k < i; k++) begin
            a_dly[k] <= a_dly[k-1];
            b_dly[k] <= b_dly[k-1];
          end
        end
      end

      assign a_lane[i] = a_dly[i-1];
      assign b_lane[i] = b_dly[i-1];
    end
  end

  always_comb begin
    for (int i = 0; i < DIM; i++) begin
      o_west_col[i]  = a_lane[i];
      o_south_row[i] = b_lane[i];
    end
  end

endmodule

//--- hdl/pe_array.sv
module pe_array (
  input  logic          clk,
  input  logic          i_reset,
  pe_ctrl_if.array      ctrl,
  input  rsa_pkg::row_t i_west_col,
  input  rsa_pkg::row_t i_south_row,
  output rsa_pkg::row_t o_acc_row
);
  import rsa_pkg::*;

  // per-PE outputs, indexed [row][col]
  word_t east_w  [DIM][DIM];
  word_t north_w [DIM][DIM];
  word_t acc_w   [DIM][DIM];

  for (genvar r = 0; r < DIM; r++) begin : g_row
    for (genvar c = 0; c < DIM; c++) begin : g_col
      word_t west_in;
      word_t south_in;

      // west edge takes lane r of the A column
      if (c == 0) begin : g_west_edge
        assign west_in = i_west_col[r];
      end else begin : g_west_chain
        assign west_in = east_w[r][c-1];
      end

      // south edge takes lane c of the B row
      if (r == 0) begin : g_south_edge
        assign south_in = i_south_row[c];
      end else begin : g_south_chain
        assign south_in = north_w[r-1][c];
      end

      pe_mac u_pe (
        .clk     (clk),
        .i_reset (i_reset),
        .i_clear (ctrl.clear),
        .i_en    (ctrl.calc_en),
        .i_west  (west_in),
        .i_south (south_in),
        .o_east  (east_w[r][c]),
        .o_north (north_w[r][c]),
        .o_acc   (acc_w[r][c])
      );
    end
  end

  // one accumulator row out per cycle during drain
  always_comb begin
    for (int c = 0; c < DIM; c++) begin
      o_acc_row[c] = acc_w[ctrl.row_sel][c];
    end
  end

endmodule

//--- hdl/pe_config.sv
module pe_config (
  input  logic         clk,
  input  logic         i_reset,
  input  logic         i_start,
  input  rsa_pkg::op_e i_op,
  bank_if.ctl          bank,
  pe_ctrl_if.ctl       ctrl,
  output rsa_pkg::op_e o_mode,
  output logic         o_busy,
  output logic         o_done
);
  import rsa_pkg::*;

  cfg_state_e state_q;
  step_t      step_q;
  op_e        mode_q;
  logic       busy_q;
  logic       done_q;

  // array controls, one cycle behind the state
  logic       clear_q;
  logic       calc_en_q;
  logic       feed_valid_q;

  // write-back follows each drain row by one cycle
  logic       wr_q;
  lane_t      wr_row_q;

  logic       start_ok;
  logic       feed_rd;
  logic       drain;

  // start only counts while idle
  assign start_ok = (state_q == ST_IDLE) && i_start;
  // first DIM steps of calc read A and B
  assign feed_rd  = (state_q == ST_CALC) && (step_q <= LANE_LAST);
  assign drain    = (state_q == ST_DRAIN);

  always_ff @(posedge clk) begin
    if (i_reset) begin
      state_q <= ST_IDLE;
      step_q  <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (i_start) begin
            state_q <= ST_CALC;
            step_q  <= '0;
          end
        end
        ST_CALC: begin
          // hold until the far corner PE has its last product
          if (step_q == CALC_LAST) begin
            state_q <= ST_DRAIN;
            step_q  <= '0;
          end else begin
            step_q <= step_q + 1'b1;
          end
        end
        ST_DRAIN: begin
          // one accumulator row per step
          if (step_q == LANE_LAST) begin
            state_q <= ST_DONE;
            step_q  <= '0;
          end else begin
            step_q <= step_q + 1'b1;
          end
        end
        ST_DONE: begin
          // last write-back happens here
          state_q <= ST_IDLE;
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      mode_q       <= OP_MUL;
      busy_q       <= 1'b0;
      done_q       <= 1'b0;
      clear_q      <= 1'b0;
      calc_en_q    <= 1'b0;
      feed_valid_q <= 1'b0;
      wr_q         <= 1'b0;
    end else begin
      // op latched once per run
      if (start_ok) begin
        mode_q <= i_op;
      end
      if (start_ok) begin
        busy_q <= 1'b1;
      end else if (state_q == ST_DONE) begin
        busy_q <= 1'b0;
      end
      done_q       <= (state_q == ST_DONE);
      // accumulators zeroed in the first calc cycle
      clear_q      <= start_ok;
      // enable spans calc steps shifted by one
      calc_en_q    <= (state_q == ST_CALC);
      // read data lands one cycle after the enable
      feed_valid_q <= feed_rd;
      wr_q         <= drain;
    end
  end

  // row index for the pending write-back
  always_ff @(posedge clk) begin
    wr_row_q <= lane_t'(step_q);
  end

  // port a: A columns in calc, M rows in drain
  assign bank.en_a   = feed_rd | drain;
  assign bank.addr_a = drain ? (M_BASE + bank_addr_t'(step_q))
                             : (A_BASE + bank_addr_t'(step_q));
  // port b: B rows in calc, C rows after drain
  assign bank.en_b   = feed_rd | wr_q;
  assign bank.we_b   = wr_q;
  assign bank.addr_b = wr_q ? (C_BASE + bank_addr_t'(wr_row_q))
                            : (B_BASE + bank_addr_t'(step_q));

  assign ctrl.clear       = clear_q;
  assign ctrl.calc_en     = calc_en_q;
  assign ctrl.feed_valid  = feed_valid_q;
  assign ctrl.row_sel     = drain ? lane_t'(step_q) : '0;
  assign ctrl.drain_valid = drain;

  assign o_mode = mode_q;
  assign o_busy = busy_q;
  assign o_done = done_q;

endmodule

//--- hdl/pe_mac.sv
module pe_mac (
  input  logic           clk,
  input  logic           i_reset,
  input  logic           i_clear,
  input  logic           i_en,
  input  rsa_pkg::word_t i_west,
  input  rsa_pkg::word_t i_south,
  output rsa_pkg::word_t o_east,
  output rsa_pkg::word_t o_north,
  output rsa_pkg::word_t o_acc
);
  import rsa_pkg::*;

  // A operand moving east
  word_t east_q;
  // B operand moving north
  word_t north_q;
  // output-stationary sum
  word_t acc_q;
  word_t prod;

  // only the low word of the product is kept
  assign prod = i_west * i_south;

  always_ff @(posedge clk) begin
    if (i_reset || i_clear) begin
      east_q  <= '0;
      north_q <= '0;
      acc_q   <= '0;
    end else if (i_en) begin
      east_q  <= i_west;
      north_q <= i_south;
      // sum wraps mod 2^16
      acc_q   <= acc_q + prod;
    end
  end

  assign o_east  = east_q;
  assign o_north = north_q;
  assign o_acc   = acc_q;

  // sequencer never clears in a cycle that also accumulates
  a_clear_not_en : assert property (
    @(posedge clk) disable iff (i_reset) !(i_clear && i_en)
  ) else $error("pe_mac: clear and enable high together");

endmodule

//--- hdl/rsa.sv
// bank ports, engine side
interface bank_if;
  import rsa_pkg::*;

  logic       en_a;
  bank_addr_t addr_a;
  row_t       dout_a;
  logic       en_b;
  logic       we_b;
  bank_addr_t addr_b;
  row_t       din_b;
  row_t       dout_b;

  modport ctl  (output en_a, addr_a, en_b, we_b, addr_b);
  modport mem  (input en_a, addr_a, en_b, we_b, addr_b, din_b, output dout_a, dout_b);
  modport feed (input dout_a, dout_b);
  modport out  (input dout_a, we_b, output din_b);
endinterface

// sequencer controls to the datapath
interface pe_ctrl_if;
  import rsa_pkg::*;

  logic  clear;
  logic  calc_en;
  logic  feed_valid;
  lane_t row_sel;
  logic  drain_valid;

  modport ctl   (output clear, calc_en, feed_valid, row_sel, drain_valid);
  modport array (input clear, calc_en, row_sel);
  modport feed  (input feed_valid);
  modport out   (input drain_valid);
endinterface

module rsa (
  input  logic                clk,
  input  logic                i_reset,
  input  logic                i_wr_en,
  input  rsa_pkg::bank_addr_t i_wr_addr,
  input  rsa_pkg::row_t       i_wr_data,
  input  logic                i_rd_en,
  input  rsa_pkg::bank_addr_t i_rd_addr,
  output rsa_pkg::row_t       o_rd_data,
  output logic                o_rd_val,
  input  logic                i_start,
  input  rsa_pkg::op_e        i_op,
  output logic                o_busy,
  output logic                o_done
);
  import rsa_pkg::*;

  bank_if    bank_bus ();
  pe_ctrl_if ctrl_bus ();

  op_e  run_mode;
  // skewed operands into the array edges
  row_t west_col;
  row_t south_row;
  // selected accumulator row
  row_t acc_row;

  pe_config u_pe_config (
    .clk     (clk),
    .i_reset (i_reset),
    .i_start (i_start),
    .i_op    (i_op),
    .bank    (bank_bus),
    .ctrl    (ctrl_bus),
    .o_mode  (run_mode),
    .o_busy  (o_busy),
    .o_done  (o_done)
  );

  temp_bank u_temp_bank (
    .clk       (clk),
    .i_reset   (i_reset),
    .bank      (bank_bus),
    .i_wr_en   (i_wr_en),
    .i_wr_addr (i_wr_addr),
    .i_wr_data (i_wr_data),
    .i_rd_en   (i_rd_en),
    .i_rd_addr (i_rd_addr),
    .o_rd_data (o_rd_data),
    .o_rd_val  (o_rd_val)
  );

  operand_feed u_operand_feed (
    .clk         (clk),
    .i_reset     (i_reset),
    .bank        (bank_bus),
    .ctrl        (ctrl_bus),
    .o_west_col  (west_col),
    .o_south_row (south_row)
  );

  pe_array u_pe_array (
    .clk         (clk),
    .i_reset     (i_reset),
    .ctrl        (ctrl_bus),
    .i_west_col  (west_col),
    .i_south_row (south_row),
    .o_acc_row   (acc_row)
  );

  c_out_stage u_c_out_stage (
    .clk       (clk),
    .i_reset   (i_reset),
    .i_mode    (run_mode),
    .ctrl      (ctrl_bus),
    .i_acc_row (acc_row),
    .bank      (bank_bus)
  );

  // host stays off the bank for the whole run
  a_host_idle : assert property (
    @(posedge clk) disable iff (i_reset) o_busy |-> !(i_wr_en || i_rd_en)
  ) else $error("rsa: host bank access while busy");

endmodule

//--- hdl/rsa_pkg.sv
package rsa_pkg;

  // array side, also the lane count of one bank row
  localparam int DIM = 4;
  // data word width
  localparam int DW = 16;

  // bank geometry
  localparam int BANK_DEPTH = 16;
  localparam int BANK_AW = $clog2(BANK_DEPTH);
  localparam int LANE_W = $clog2(DIM);

  // first bank read until last product lands in the far corner PE
  localparam int CALC_CYCLES = 3 * DIM - 1;
  localparam int STEP_W = $clog2(CALC_CYCLES);

  // one data word, wraps mod 2^16
  typedef logic [DW-1:0] word_t;
  // one bank row, lane i in word i
  typedef logic [DIM-1:0][DW-1:0] row_t;
  typedef logic [BANK_AW-1:0] bank_addr_t;
  // row index inside the array
  typedef logic [LANE_W-1:0] lane_t;
  // sequencer step counter
  typedef logic [STEP_W-1:0] step_t;

  // A stored column-wise, row k holds column k
  localparam bank_addr_t A_BASE = bank_addr_t'(0);
  // B stored row-wise
  localparam bank_addr_t B_BASE = bank_addr_t'(4);
  // addend for the MAC mode, row-wise
  localparam bank_addr_t M_BASE = bank_addr_t'(8);
  // result rows land here
  localparam bank_addr_t C_BASE = bank_addr_t'(12);

  // last step of the calc stage
  localparam step_t CALC_LAST = step_t'(CALC_CYCLES - 1);
  // last step of a per-lane walk (feed reads, drain rows)
  localparam step_t LANE_LAST = step_t'(DIM - 1);

  typedef enum logic {
    OP_MUL,
    OP_MAC
  } op_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_CALC,
    ST_DRAIN,
    ST_DONE
  } cfg_state_e;

endpackage

//--- hdl/temp_bank.sv
module temp_bank (
  input  logic               clk,
  input  logic               i_reset,
  bank_if.mem                bank,
  input  logic               i_wr_en,
  input  rsa_pkg::bank_addr_t i_wr_addr,
  input  rsa_pkg::row_t      i_wr_data,
  input  logic               i_rd_en,
  input  rsa_pkg::bank_addr_t i_rd_addr,
  output rsa_pkg::row_t      o_rd_data,
  output logic               o_rd_val
);
  import rsa_pkg::*;

  row_t mem [BANK_DEPTH];

  // port a, engine reads or host reads
  logic       a_en;
  bank_addr_t a_addr;
  row_t       dout_a_q;
  // port b, engine read/write or host writes
  logic       b_en;
  logic       b_we;
  bank_addr_t b_addr;
  row_t       b_din;
  row_t       dout_b_q;
  logic       rd_val_q;

  // engine has the port whenever it enables it
  assign a_en   = bank.en_a | i_rd_en;
  assign a_addr = bank.en_a ? bank.addr_a : i_rd_addr;
  assign b_en   = bank.en_b | i_wr_en;
  assign b_we   = bank.en_b ? bank.we_b : i_wr_en;
  assign b_addr = bank.en_b ? bank.addr_b : i_wr_addr;
  assign b_din  = bank.en_b ? bank.din_b : i_wr_data;

  always_ff @(posedge clk) begin
    if (a_en) begin
      dout_a_q <= mem[a_addr];
    end
  end

  // write-first is not needed, read and write never share a cycle here
  always_ff @(posedge clk) begin
    if (b_en) begin
      if (b_we) begin
        mem[b_addr] <= b_din;
      end else begin
        dout_b_q <= mem[b_addr];
      end
    end
  end

  // host read data one cycle after the request
  always_ff @(posedge clk) begin
    if (i_reset) begin
      rd_val_q <= 1'b0;
    end else begin
      rd_val_q <= i_rd_en & ~bank.en_a;
    end
  end

  assign bank.dout_a = dout_a_q;
  assign bank.dout_b = dout_b_q;
  assign o_rd_data   = dout_a_q;
  assign o_rd_val    = rd_val_q;

  // host and sequencer never touch the bank in the same cycle
  a_no_overlap : assert property (
    @(posedge clk) disable iff (i_reset)
      !((i_rd_en || i_wr_en) && (bank.en_a || bank.en_b))
  ) else $error("temp_bank: host access collides with engine access");

endmodule

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f src.f --top-module rsa_tb -o rsa_sim
out=$(./obj_dir/rsa_sim 2>&1) || true
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx "Result: PASSED"; then
  exit 0
fi
exit 1

//--- src.f
hdl/rsa_pkg.sv
hdl/pe_mac.sv
hdl/pe_array.sv
hdl/operand_feed.sv
hdl/c_out_stage.sv
hdl/temp_bank.sv
hdl/pe_config.sv
hdl/rsa.sv
test/rsa_tb.sv

//--- test/rsa_tb.sv
module rsa_tb;
  import rsa_pkg::*;

  // cycles allowed for one run to raise o_done
  localparam int RUN_TIMEOUT = 100;
  localparam int NUM_RUNS = 4;

  logic       clk;
  logic       i_reset;
  logic       i_wr_en;
  bank_addr_t i_wr_addr;
  row_t       i_wr_data;
  logic       i_rd_en;
  bank_addr_t i_rd_addr;
  row_t       o_rd_data;
  logic       o_rd_val;
  logic       i_start;
  op_e        i_op;
  logic       o_busy;
  logic       o_done;

  integer seed;
  // model matrices, indexed [row][col]
  word_t a_m [DIM][DIM];
  word_t b_m [DIM][DIM];
  word_t m_m [DIM][DIM];
  bank_addr_t probe_addr;
  row_t       probe_row;
  row_t       rd_row;
  op_e        run_op;

  rsa rsa_i (
    .clk       (clk),
    .i_reset   (i_reset),
    .i_wr_en   (i_wr_en),
    .i_wr_addr (i_wr_addr),
    .i_wr_data (i_wr_data),
    .i_rd_en   (i_rd_en),
    .i_rd_addr (i_rd_addr),
    .o_rd_data (o_rd_data),
    .o_rd_val  (o_rd_val),
    .i_start   (i_start),
    .i_op      (i_op),
    .o_busy    (o_busy),
    .o_done    (o_done)
  );

  always #4 clk = ~clk;

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped at first failure");
  endtask

  task automatic compare_row(input row_t got, input row_t exp, input string what);
    if (got !== exp) begin
      stop_run($sformatf("ERROR at time %0t: %s: got %h, expected %h",
                         $time, what, got, exp));
    end
  endtask

  task automatic compare_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      stop_run($sformatf("ERROR at time %0t: %s: got %b, expected %b",
                         $time, what, got, exp));
    end
  endtask

  function automatic row_t random_row();
    row_t r;
    for (int j = 0; j < DIM; j++) begin
      r[j] = word_t'($random(seed));
    end
    return r;
  endfunction

  // all host tasks start and end on a falling edge
  task automatic write_row(input bank_addr_t addr, input row_t data);
    i_wr_en   = 1'b1;
    i_wr_addr = addr;
    i_wr_data = data;
    @(negedge clk);
    i_wr_en = 1'b0;
  endtask

  task automatic read_row(input bank_addr_t addr, output row_t data);
    i_rd_en   = 1'b1;
    i_rd_addr = addr;
    @(negedge clk);
    i_rd_en = 1'b0;
    compare_bit(o_rd_val, 1'b1, "o_rd_val one cycle after i_rd_en");
    data = o_rd_data;
  endtask

  // A goes in column-wise, B and M row-wise
  function automatic row_t region_row(input int region, input int k);
    row_t r;
    for (int j = 0; j < DIM; j++) begin
      if (region == 0) begin
        r[j] = a_m[j][k];
      end else if (region == 1) begin
        r[j] = b_m[k][j];
      end else begin
        r[j] = m_m[k][j];
      end
    end
    return r;
  endfunction

  task automatic load_operands();
    for (int r = 0; r < DIM; r++) begin
      for (int c = 0; c < DIM; c++) begin
        a_m[r][c] = word_t'($random(seed));
        b_m[r][c] = word_t'($random(seed));
        m_m[r][c] = word_t'($random(seed));
      end
    end
    for (int k = 0; k < DIM; k++) begin
      write_row(A_BASE + bank_addr_t'(k), region_row(0, k));
      write_row(B_BASE + bank_addr_t'(k), region_row(1, k));
      write_row(M_BASE + bank_addr_t'(k), region_row(2, k));
    end
  endtask

  // row i of A*B, plus row i of M for the MAC op, all mod 2^16
  function automatic row_t expected_c_row(input op_e op, input int i);
    row_t  r;
    word_t acc;
    for (int j = 0; j < DIM; j++) begin
      acc = (op == OP_MAC) ? m_m[i][j] : '0;
      for (int k = 0; k < DIM; k++) begin
        acc = acc + word_t'(a_m[i][k] * b_m[k][j]);
      end
      r[j] = acc;
    end
    return r;
  endfunction

  task automatic run_engine(input op_e op, input bit noisy);
    int cycles;
    bit done_seen;
    i_op    = op;
    i_start = 1'b1;
    @(negedge clk);
    i_start = 1'b0;
    compare_bit(o_busy, 1'b1, "o_busy one cycle after i_start");
    cycles    = 0;
    done_seen = 1'b0;
    while (!done_seen) begin
      @(negedge clk);
      cycles++;
      i_start = 1'b0;
      if (o_done) begin
        done_seen = 1'b1;
      end else if (cycles > RUN_TIMEOUT) begin
        stop_run("timeout: o_done never went high during the run");
      end else begin
        compare_bit(o_busy, 1'b1, "o_busy during run");
        if (noisy) begin
          // stray starts and a changing op must not disturb the run
          i_start = ($random(seed) & 1) != 0;
          i_op    = (($random(seed) & 1) != 0) ? OP_MAC : OP_MUL;
        end
      end
    end
    compare_bit(o_busy, 1'b0, "o_busy in the o_done cycle");
    i_op = op;
    @(negedge clk);
    compare_bit(o_done, 1'b0, "o_done one cycle after pulse");
    compare_bit(o_busy, 1'b0, "o_busy after o_done");
  endtask

  task automatic check_results(input op_e op);
    for (int i = 0; i < DIM; i++) begin
      read_row(C_BASE + bank_addr_t'(i), rd_row);
      compare_row(rd_row, expected_c_row(op, i), $sformatf("C row %0d", i));
    end
  endtask

  task automatic check_operands_kept();
    for (int k = 0; k < DIM; k++) begin
      read_row(A_BASE + bank_addr_t'(k), rd_row);
      compare_row(rd_row, region_row(0, k), $sformatf("A row %0d after run", k));
      read_row(B_BASE + bank_addr_t'(k), rd_row);
      compare_row(rd_row, region_row(1, k), $sformatf("B row %0d after run", k));
      read_row(M_BASE + bank_addr_t'(k), rd_row);
      compare_row(rd_row, region_row(2, k), $sformatf("M row %0d after run", k));
    end
  endtask

  initial begin
    seed      = 32'hc12d_67d2;
    clk       = 1'b0;
    i_reset   = 1'b1;
    i_wr_en   = 1'b0;
    i_wr_addr = '0;
    i_wr_data = '0;
    i_rd_en   = 1'b0;
    i_rd_addr = '0;
    i_start   = 1'b0;
    i_op      = OP_MUL;
    repeat (3) @(posedge clk);
    @(negedge clk);
    i_reset = 1'b0;
    compare_bit(o_busy, 1'b0, "o_busy after reset");
    compare_bit(o_done, 1'b0, "o_done after reset");
    compare_bit(o_rd_val, 1'b0, "o_rd_val after reset");

    // host write then read back one random row
    probe_addr = bank_addr_t'($random(seed));
    probe_row  = random_row();
    write_row(probe_addr, probe_row);
    compare_bit(o_rd_val, 1'b0, "o_rd_val before read");
    read_row(probe_addr, rd_row);
    compare_row(rd_row, probe_row, "host write/read row");
    @(negedge clk);
    compare_bit(o_rd_val, 1'b0, "o_rd_val two cycles after i_rd_en");

    load_operands();
    run_engine(OP_MUL, 1'b0);
    check_results(OP_MUL);
    check_operands_kept();

    load_operands();
    run_engine(OP_MAC, 1'b0);
    check_results(OP_MAC);
    check_operands_kept();

    // back-to-back runs with stray starts in flight
    for (int n = 0; n < NUM_RUNS; n++) begin
      load_operands();
      run_op = (($random(seed) & 1) != 0) ? OP_MAC : OP_MUL;
      run_engine(run_op, 1'b1);
      check_results(run_op);
      check_operands_kept();
    end

    $display("Result: PASSED");
    $finish;
  end

endmodule
